// File: logic/vmq_macros.svh
`ifndef VMQ_MACROS_SVH
`define VMQ_MACROS_SVH

// bus side
`define VMQ_ADDR_W 32
`define VMQ_MBUS_W 32

// vector side
`define VMQ_RVV_W 64

// log2 of every buffer depth, also the longest burst
`define VMQ_DEPTH_BITS 4

`endif

// File: logic/vmq_pkg.sv
`include "vmq_macros.svh"

package vmq_pkg;

    typedef logic [`VMQ_ADDR_W-1:0] addr_t;
    typedef logic [`VMQ_MBUS_W-1:0] word_t;
    typedef logic [`VMQ_RVV_W-1:0]  elem_t;  // high half lives at addr + 4
    typedef logic [`VMQ_DEPTH_BITS:0] count_t;

    // store queue entry, one vector element
    typedef struct packed {
        addr_t addr;
        elem_t data;
        logic  last;
    } st_entry_t;

    // load queue entry
    typedef struct packed {
        addr_t addr;
        logic  last;
    } ld_entry_t;

    typedef enum logic [1:0] {
        REG_CTRL    = 2'd0,  // bit 0 load enable, bit 1 store enable
        REG_STATUS  = 2'd1,  // bit 0 sticky bus error, w1c
        REG_LD_DONE = 2'd2,
        REG_ST_DONE = 2'd3
    } reg_addr_t;

endpackage

// File: logic/sync_fifo.sv
`timescale 1ns/10ps
`include "vmq_macros.svh"

module sync_fifo
    import vmq_pkg::*;
#(
    parameter type payload_t = word_t,
    parameter int  depth_bits = `VMQ_DEPTH_BITS
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty,
    output count_t   level
);
    localparam int depth = 1 << depth_bits;

    payload_t              mem [depth];
    logic [depth_bits-1:0] wr_ptr;
    logic [depth_bits-1:0] rd_ptr;
    count_t                count;
    logic                  do_push;
    logic                  do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign full     = (count == count_t'(depth));
    assign empty    = (count == '0);
    assign level    = count;
    assign pop_data = mem[rd_ptr];  // head visible with no read latency

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + count_t'(do_push) - count_t'(do_pop);
        end
    end

    // upstream logic is expected to respect full and empty
    no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && full))
        else $error("sync_fifo push while full");
    no_underflow: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
        else $error("sync_fifo pop while empty");

endmodule

// File: logic/store_beat_splitter.sv
`timescale 1ns/10ps
`include "vmq_macros.svh"

module store_beat_splitter
    import vmq_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  enable,
    input  logic  st_valid,
    input  addr_t st_addr,
    input  elem_t st_data,
    input  logic  st_last,
    input  logic  aw_ready,
    input  logic  b_valid,
    input  logic  b_err,
    output logic  st_full,
    output logic  aw_valid,
    output addr_t aw_addr,
    output word_t w_data,
    output logic  st_done,
    output logic  bus_error
);
    localparam int word_bytes = `VMQ_MBUS_W / 8;

    st_entry_t                  in_entry;
    st_entry_t                  head;
    logic                       fifo_empty;
    logic                       half;       // 0 low word, 1 high word
    logic                       beat_fire;
    logic                       last_sent;
    logic [`VMQ_DEPTH_BITS+1:0] issued_cnt; // two beats per element
    logic [`VMQ_DEPTH_BITS+1:0] resp_cnt;

    assign in_entry = '{addr: st_addr, data: st_data, last: st_last};

    sync_fifo #(
        .payload_t(st_entry_t)
    ) st_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (st_valid && !st_full),
        .push_data(in_entry),
        .pop      (beat_fire && half),    // entry leaves after its high beat
        .pop_data (head),
        .full     (st_full),
        .empty    (fifo_empty),
        .level    ()
    );

    // a pair already started finishes even when the path gets disabled;
    // after the last beat of a burst, wait for all responses
    assign aw_valid  = !fifo_empty && !last_sent && (enable || half);
    assign aw_addr   = half ? head.addr + addr_t'(word_bytes) : head.addr;
    assign w_data    = half ? head.data[`VMQ_RVV_W-1:`VMQ_MBUS_W] : head.data[`VMQ_MBUS_W-1:0];
    assign beat_fire = aw_valid && aw_ready;

    assign st_done   = last_sent && (resp_cnt == issued_cnt);
    assign bus_error = b_valid && b_err;

    always_ff @(posedge clk) begin
        if (reset) begin
            half       <= 1'b0;
            last_sent  <= 1'b0;
            issued_cnt <= '0;
            resp_cnt   <= '0;
        end else begin
            if (beat_fire) begin
                half       <= !half;
                issued_cnt <= issued_cnt + 1'b1;
                if (half && head.last) begin
                    last_sent <= 1'b1;
                end
            end
            if (b_valid) begin
                resp_cnt <= resp_cnt + 1'b1;
            end
            if (st_done) begin  // burst closed, start counting the next one
                last_sent  <= 1'b0;
                issued_cnt <= '0;
                resp_cnt   <= '0;
            end
        end
    end

    // every response must belong to a beat already accepted by the bus
    b_has_beat: assert property (@(posedge clk) disable iff (reset)
        b_valid |-> (resp_cnt < issued_cnt))
        else $error("write response with no beat outstanding");

endmodule

// File: logic/load_beat_merger.sv
`timescale 1ns/10ps
`include "vmq_macros.svh"

module load_beat_merger
    import vmq_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  enable,
    input  logic  ld_req,
    input  addr_t ld_addr,
    input  logic  ld_last,
    input  logic  ar_ready,
    input  logic  r_valid,
    input  word_t r_data,
    input  logic  ld_ready,
    output logic  ld_full,
    output logic  ar_valid,
    output addr_t ar_addr,
    output logic  ld_valid,
    output elem_t ld_data,
    output logic  ld_done
);
    localparam int word_bytes = `VMQ_MBUS_W / 8;

    ld_entry_t in_entry;
    ld_entry_t head;
    word_t     lo_word;
    word_t     hi_word;
    count_t    lo_level;
    count_t    hi_level;
    count_t    burst_len;   // elements issued in this burst
    count_t    out_cnt;
    logic      addr_empty;
    logic      half;
    logic      rd_half;     // half of the read in flight
    logic      outstanding;
    logic      len_final;   // last address of the burst issued
    logic      streaming;
    logic      ar_fire;
    logic      lo_push;
    logic      hi_push;
    logic      out_fire;

    assign in_entry = '{addr: ld_addr, last: ld_last};

    sync_fifo #(
        .payload_t(ld_entry_t)
    ) addr_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (ld_req && !ld_full),
        .push_data(in_entry),
        .pop      (ar_fire && half),
        .pop_data (head),
        .full     (ld_full),
        .empty    (addr_empty),
        .level    ()
    );

    sync_fifo #(
        .payload_t(word_t)
    ) lo_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (lo_push),
        .push_data(r_data),
        .pop      (out_fire),
        .pop_data (lo_word),
        .full     (),
        .empty    (),
        .level    (lo_level)
    );

    sync_fifo #(
        .payload_t(word_t)
    ) hi_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (hi_push),
        .push_data(r_data),
        .pop      (out_fire),
        .pop_data (hi_word),
        .full     (),
        .empty    (),
        .level    (hi_level)
    );

    assign ar_valid = !addr_empty && !outstanding && !len_final && (enable || half);
    assign ar_addr  = half ? head.addr + addr_t'(word_bytes) : head.addr;
    assign ar_fire  = ar_valid && ar_ready;

    assign lo_push  = r_valid && outstanding && !rd_half;
    assign hi_push  = r_valid && outstanding && rd_half;

    assign ld_valid = streaming;
    assign ld_data  = {hi_word, lo_word};
    assign out_fire = ld_valid && ld_ready;
    assign ld_done  = out_fire && (out_cnt == burst_len - 1'b1);

    always_ff @(posedge clk) begin
        if (reset) begin
            half        <= 1'b0;
            rd_half     <= 1'b0;
            outstanding <= 1'b0;
            len_final   <= 1'b0;
            streaming   <= 1'b0;
            burst_len   <= '0;
            out_cnt     <= '0;
        end else begin
            if (ar_fire) begin
                half        <= !half;
                rd_half     <= half;
                outstanding <= 1'b1;
                if (half) begin
                    burst_len <= burst_len + 1'b1;
                    if (head.last) begin
                        len_final <= 1'b1;
                    end
                end
            end else if (r_valid) begin
                outstanding <= 1'b0;
            end
            // both halves of every element are back
            if (len_final && !streaming && lo_level == burst_len && hi_level == burst_len) begin
                streaming <= 1'b1;
            end
            if (out_fire) begin
                out_cnt <= out_cnt + 1'b1;
            end
            if (ld_done) begin
                streaming <= 1'b0;
                len_final <= 1'b0;
                burst_len <= '0;
                out_cnt   <= '0;
            end
        end
    end

    r_when_outstanding: assert property (@(posedge clk) disable iff (reset)
        r_valid |-> outstanding)
        else $error("read data with no read outstanding");

endmodule

// File: logic/queue_ctrl_regs.sv
`timescale 1ns/10ps

module queue_ctrl_regs
    import vmq_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      cfg_req,
    input  logic      cfg_write,
    input  reg_addr_t cfg_addr,
    input  word_t     cfg_wdata,
    input  logic      bus_error,
    input  logic      ld_done,
    input  logic      st_done,
    output logic      cfg_ack,
    output word_t     cfg_rdata,
    output logic      load_enable,
    output logic      store_enable
);
    localparam int cnt_w = 16;

    logic             access;
    logic             err_sticky;
    logic             err_clear;
    logic [cnt_w-1:0] ld_cnt;
    logic [cnt_w-1:0] st_cnt;

    // new access only on the rising phase of req
    assign access    = cfg_req && !cfg_ack;
    assign err_clear = access && cfg_write && (cfg_addr == REG_STATUS) && cfg_wdata[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_ack      <= 1'b0;
            load_enable  <= 1'b1;
            store_enable <= 1'b1;
            err_sticky   <= 1'b0;
            ld_cnt       <= '0;
            st_cnt       <= '0;
        end else begin
            if (access) begin
                cfg_ack <= 1'b1;
                if (cfg_write && cfg_addr == REG_CTRL) begin
                    load_enable  <= cfg_wdata[0];
                    store_enable <= cfg_wdata[1];
                end
            end else if (!cfg_req) begin
                cfg_ack <= 1'b0;
            end
            err_sticky <= (err_sticky && !err_clear) || bus_error;  // a new error wins
            ld_cnt     <= ld_cnt + cnt_w'(ld_done);
            st_cnt     <= st_cnt + cnt_w'(st_done);
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (cfg_addr)
                REG_CTRL:    cfg_rdata <= {30'b0, store_enable, load_enable};
                REG_STATUS:  cfg_rdata <= {31'b0, err_sticky};
                REG_LD_DONE: cfg_rdata <= {16'b0, ld_cnt};
                REG_ST_DONE: cfg_rdata <= {16'b0, st_cnt};
                default:     cfg_rdata <= '0;
            endcase
        end
    end

    // request fields stay put while req is held
    req_fields_stable: assert property (@(posedge clk) disable iff (reset)
        (cfg_req && $past(cfg_req)) |->
            ($stable(cfg_write) && $stable(cfg_addr) && $stable(cfg_wdata)))
        else $error("cfg request fields changed while cfg_req was held");

endmodule

// File: logic/vec_mem_queue.sv
`timescale 1ns/10ps

module vec_mem_queue
    import vmq_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    // vector store side
    input  logic      st_valid,
    input  addr_t     st_addr,
    input  elem_t     st_data,
    input  logic      st_last,
    output logic      st_full,
    output logic      st_done,
    // vector load side
    input  logic      ld_req,
    input  addr_t     ld_addr,
    input  logic      ld_last,
    output logic      ld_full,
    output logic      ld_valid,
    output elem_t     ld_data,
    input  logic      ld_ready,
    output logic      ld_done,
    // memory bus
    output logic      aw_valid,
    input  logic      aw_ready,
    output addr_t     aw_addr,
    output word_t     w_data,
    input  logic      b_valid,
    input  logic      b_err,
    output logic      ar_valid,
    input  logic      ar_ready,
    output addr_t     ar_addr,
    input  logic      r_valid,
    input  word_t     r_data,
    // register port
    input  logic      cfg_req,
    input  logic      cfg_write,
    input  reg_addr_t cfg_addr,
    input  word_t     cfg_wdata,
    output logic      cfg_ack,
    output word_t     cfg_rdata
);
    logic load_enable;
    logic store_enable;
    logic bus_error;

    queue_ctrl_regs u_regs (
        .clk, .reset, .cfg_req, .cfg_write, .cfg_addr, .cfg_wdata,
        .bus_error, .ld_done, .st_done,
        .cfg_ack, .cfg_rdata, .load_enable, .store_enable
    );

    store_beat_splitter u_store (
        .clk, .reset, .enable(store_enable),
        .st_valid, .st_addr, .st_data, .st_last,
        .aw_ready, .b_valid, .b_err,
        .st_full, .aw_valid, .aw_addr, .w_data, .st_done, .bus_error
    );

    load_beat_merger u_load (
        .clk, .reset, .enable(load_enable),
        .ld_req, .ld_addr, .ld_last,
        .ar_ready, .r_valid, .r_data, .ld_ready,
        .ld_full, .ar_valid, .ar_addr, .ld_valid, .ld_data, .ld_done
    );

endmodule

// File: verification/vmq_clock_gen.sv
`timescale 1ns/10ps

module vmq_clock_gen #(
    parameter real period_ns    = 4.0,
    parameter int  reset_cycles = 3
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);  // released on a falling edge like every other input
        reset = 1'b0;
    end

endmodule

// File: verification/vmq_mem_model.sv
`timescale 1ns/10ps

module vmq_mem_model
    import vmq_pkg::*;
#(
    parameter int    words    = 1024,
    parameter addr_t err_base = 32'h0000_0f00
) (
    input  logic  clk,
    input  logic  aw_valid,
    input  addr_t aw_addr,
    input  word_t w_data,
    output logic  aw_ready,
    output logic  b_valid,
    output logic  b_err,
    input  logic  ar_valid,
    input  addr_t ar_addr,
    output logic  ar_ready,
    output logic  r_valid,
    output word_t r_data
);
    word_t mem [words];
    int    cycle;
    int    b_due [$];      // response schedule, in beat order
    logic  b_err_q [$];
    logic  rd_busy;
    int    rd_due;
    word_t rd_word;

    function automatic int word_index(input addr_t a);
        return int'(a >> 2) % words;
    endfunction

    // everything is decided on the falling edge; a beat that sees valid and
    // ready here completes on the next rising edge
    initial begin
        for (int i = 0; i < words; i++) begin
            mem[i] = ~word_t'(i * 4);  // inverse of the byte address
        end
        aw_ready = 1'b0;
        ar_ready = 1'b0;
        b_valid  = 1'b0;
        b_err    = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        cycle    = 0;
        rd_busy  = 1'b0;
        rd_due   = 0;
        rd_word  = '0;
        forever begin
            @(negedge clk);
            cycle++;
            b_valid = 1'b0;
            b_err   = 1'b0;
            r_valid = 1'b0;
            if (b_due.size() != 0 && b_due[0] <= cycle) begin
                void'(b_due.pop_front());
                b_valid = 1'b1;
                b_err   = b_err_q.pop_front();
            end
            aw_ready = ($urandom % 4) != 0;
            if (aw_valid && aw_ready) begin
                if (aw_addr < err_base) begin
                    mem[word_index(aw_addr)] = w_data;
                end
                b_due.push_back(cycle + 1 + int'($urandom % 4));
                b_err_q.push_back(aw_addr >= err_base);
            end
            if (rd_busy && rd_due <= cycle) begin
                r_valid = 1'b1;
                r_data  = rd_word;
                rd_busy = 1'b0;
            end
            ar_ready = ($urandom % 3) != 0;
            if (ar_valid && ar_ready && !rd_busy) begin
                rd_busy = 1'b1;
                rd_word = mem[word_index(ar_addr)];
                rd_due  = cycle + 1 + int'($urandom % 5);
            end
        end
    end

endmodule

// File: verification/vmq_tb.sv
`timescale 1ns/10ps
`include "vmq_macros.svh"

module vmq_tb
    import vmq_pkg::*;
();
    localparam addr_t err_base       = 32'h0000_0f00;
    localparam int    mem_words      = 1024;
    localparam int    rand_bursts    = 20;
    localparam int    max_elems      = 8 * 2 + 16 + 4 + 4 * 2 + rand_bursts * (1 << `VMQ_DEPTH_BITS);
    localparam int    timeout_cycles = max_elems * 200 + 2000;

    logic      clk;
    logic      reset;
    logic      st_valid;
    addr_t     st_addr;
    elem_t     st_data;
    logic      st_last;
    logic      st_full;
    logic      st_done;
    logic      ld_req;
    addr_t     ld_addr;
    logic      ld_last;
    logic      ld_full;
    logic      ld_valid;
    elem_t     ld_data;
    logic      ld_ready;
    logic      ld_done;
    logic      aw_valid;
    logic      aw_ready;
    addr_t     aw_addr;
    word_t     w_data;
    logic      b_valid;
    logic      b_err;
    logic      ar_valid;
    logic      ar_ready;
    addr_t     ar_addr;
    logic      r_valid;
    word_t     r_data;
    logic      cfg_req;
    logic      cfg_write;
    reg_addr_t cfg_addr;
    word_t     cfg_wdata;
    logic      cfg_ack;
    word_t     cfg_rdata;

    word_t  shadow [mem_words];     // words the bus has accepted
    bit     shadow_ok [mem_words];
    elem_t  exp_data [$];
    count_t exp_len [$];
    count_t got_len;
    int     st_bursts;
    int     ld_bursts;
    int     st_seen;
    int     ld_seen;
    bit     rand_ready;

    vmq_clock_gen clock_gen (.clk(clk), .reset(reset));
    vmq_mem_model mem_model (.*);
    vec_mem_queue dut (.*);

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_elem(input string name, input elem_t got, input elem_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // stored value if the bus took a write there or else the power-on pattern
    function automatic word_t expected_word(input addr_t addr);
        int idx;
        idx = int'(addr >> 2) % mem_words;
        return shadow_ok[idx] ? shadow[idx] : ~addr;
    endfunction

    function automatic void shadow_store(input addr_t addr, input word_t data);
        int idx;
        idx = int'(addr >> 2) % mem_words;
        if (addr < err_base) begin  // error region drops the write
            shadow[idx]    = data;
            shadow_ok[idx] = 1'b1;
        end
    endfunction

    task automatic reg_access(input logic write, input reg_addr_t addr, input word_t wdata,
                              output word_t rdata);
        cfg_write = write;
        cfg_addr  = addr;
        cfg_wdata = wdata;
        cfg_req   = 1'b1;
        do @(negedge clk); while (!cfg_ack);
        rdata   = cfg_rdata;
        cfg_req = 1'b0;
        do @(negedge clk); while (cfg_ack);
    endtask

    task automatic store_burst(input addr_t base, input int n);
        addr_t addr;
        elem_t data;
        for (int i = 0; i < n; i++) begin
            addr     = base + addr_t'(i * 8);
            data     = {$urandom, $urandom};
            st_valid = 1'b1;
            st_addr  = addr;
            st_data  = data;
            st_last  = (i == n - 1);
            while (st_full) @(negedge clk);
            @(negedge clk);  // taken on the rising edge just passed
            shadow_store(addr, data[31:0]);
            shadow_store(addr + 4, data[63:32]);
        end
        st_valid = 1'b0;
        st_last  = 1'b0;
        st_bursts++;
    endtask

    task automatic load_burst(input addr_t base, input int n);
        addr_t addr;
        exp_len.push_back(count_t'(n));
        for (int i = 0; i < n; i++) begin
            addr = base + addr_t'(i * 8);
            exp_data.push_back({expected_word(addr + 4), expected_word(addr)});
            ld_req  = 1'b1;
            ld_addr = addr;
            ld_last = (i == n - 1);
            while (ld_full) @(negedge clk);
            @(negedge clk);
        end
        ld_req  = 1'b0;
        ld_last = 1'b0;
        ld_bursts++;
    endtask

    task automatic wait_stores();
        while (st_seen != st_bursts) @(negedge clk);
    endtask

    task automatic wait_loads();
        while (ld_seen != ld_bursts) @(negedge clk);
    endtask

    initial begin
        ld_ready = 1'b0;
        forever begin
            @(negedge clk);
            ld_ready = rand_ready ? (($urandom % 2) != 0) : 1'b1;
        end
    end

    // compares in the middle of the low phase where every output has settled
    initial begin
        got_len = '0;
        st_seen = 0;
        ld_seen = 0;
        forever begin
            @(negedge clk);
            #1;
            if (!reset && st_done) begin
                st_seen++;
            end
            if (!reset && ld_valid && ld_ready) begin
                if (exp_data.size() == 0) begin
                    fail_run("a load element came back that no burst asked for");
                end else begin
                    check_elem("ld_data", ld_data, exp_data.pop_front());
                    got_len++;
                    if (ld_done) begin
                        check_count("load burst length at ld_done", got_len,
                                    exp_len.pop_front());
                        got_len = '0;
                        ld_seen++;
                    end else if (got_len == exp_len[0]) begin
                        fail_run("ld_done missing on the last element of a load burst");
                    end
                end
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        fail_run($sformatf("timeout: run did not finish within %0d cycles", timeout_cycles));
    end

    initial begin
        word_t rd;
        int    len;
        addr_t base;
        void'($urandom(32'hdbb7_dbbf));
        st_valid   = 1'b0;
        st_addr    = '0;
        st_data    = '0;
        st_last    = 1'b0;
        ld_req     = 1'b0;
        ld_addr    = '0;
        ld_last    = 1'b0;
        cfg_req    = 1'b0;
        cfg_write  = 1'b0;
        cfg_addr   = REG_CTRL;
        cfg_wdata  = '0;
        rand_ready = 1'b0;
        st_bursts  = 0;
        ld_bursts  = 0;
        for (int i = 0; i < mem_words; i++) begin
            shadow_ok[i] = 1'b0;
        end
        wait (!reset);
        @(negedge clk);

        check_word("aw_valid ar_valid ld_valid ld_done st_done cfg_ack st_full ld_full",
            word_t'({aw_valid, ar_valid, ld_valid, ld_done, st_done, cfg_ack, st_full, ld_full}),
            '0);
        reg_access(1'b0, REG_CTRL, '0, rd);
        check_word("cfg_rdata REG_CTRL", rd, 32'd3);
        reg_access(1'b0, REG_STATUS, '0, rd);
        check_word("cfg_rdata REG_STATUS", rd, '0);
        reg_access(1'b0, REG_LD_DONE, '0, rd);
        check_word("cfg_rdata REG_LD_DONE", rd, '0);
        reg_access(1'b0, REG_ST_DONE, '0, rd);
        check_word("cfg_rdata REG_ST_DONE", rd, '0);

        store_burst(32'h0000_0100, 8);
        wait_stores();
        load_burst(32'h0000_0100, 8);
        wait_loads();

        rand_ready = 1'b1;
        load_burst(32'h0000_0400, 16);  // never written
        wait_loads();
        rand_ready = 1'b0;

        // entries must sit in the queue while the store path is paused
        reg_access(1'b1, REG_CTRL, 32'd1, rd);
        store_burst(32'h0000_0200, 4);
        repeat (50) begin
            @(negedge clk);
            check_word("aw_valid", word_t'(aw_valid), '0);
        end
        reg_access(1'b1, REG_CTRL, 32'd3, rd);
        wait_stores();
        reg_access(1'b0, REG_ST_DONE, '0, rd);
        check_word("cfg_rdata REG_ST_DONE", rd, word_t'(st_bursts));

        store_burst(err_base, 4);
        wait_stores();
        reg_access(1'b0, REG_STATUS, '0, rd);
        check_word("cfg_rdata REG_STATUS", rd, 32'd1);
        load_burst(err_base, 4);
        wait_loads();
        reg_access(1'b1, REG_STATUS, 32'd1, rd);
        reg_access(1'b0, REG_STATUS, '0, rd);
        check_word("cfg_rdata REG_STATUS", rd, '0);

        rand_ready = 1'b1;
        for (int k = 0; k < rand_bursts; k++) begin
            len  = 1 + int'($urandom % 16);
            base = addr_t'(($urandom % (513 - len)) * 8);  // burst stays inside memory
            if (($urandom % 2) != 0) begin
                store_burst(base, len);
                wait_stores();
            end else begin
                load_burst(base, len);
                wait_loads();
            end
        end
        reg_access(1'b0, REG_LD_DONE, '0, rd);
        check_word("cfg_rdata REG_LD_DONE", rd, word_t'(ld_bursts));
        reg_access(1'b0, REG_ST_DONE, '0, rd);
        check_word("cfg_rdata REG_ST_DONE", rd, word_t'(st_bursts));

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: all.f
+incdir+logic
logic/vmq_pkg.sv
logic/sync_fifo.sv
logic/store_beat_splitter.sv
logic/load_beat_merger.sv
logic/queue_ctrl_regs.sv
logic/vec_mem_queue.sv
verification/vmq_clock_gen.sv
verification/vmq_mem_model.sv
verification/vmq_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module vmq_tb -f all.f -o vmq_sim &&
./obj_dir/vmq_sim | grep "TEST RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
